// ==== verilog.f ====
dcache_pkg.sv
line_port_if.sv
mem_port_if.sv
dcache_line_store.sv
dcache_ctrl.sv
snoop_unit.sv
mem_arbiter.sv
dcache_top.sv
tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - line_port_if.sv
  - mem_port_if.sv
  - dcache_line_store.sv
  - dcache_ctrl.sv
  - snoop_unit.sv
  - mem_arbiter.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_dcache.sv

// ==== tb_dcache.sv ====
// Memory model stores 16 KB and aliases above it, so every address that reaches memory stays below 0x4000
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

  localparam int unsigned NumSets        = 16;
  localparam addr_t       UncachedLimit  = 32'h0000_0100;
  localparam int          ResetCycles    = 4;
  localparam int          NumAccesses    = 16;
  localparam int          HandshakeLimit = 100;

  logic       clk_i = 1'b0;
  logic       rst_n_i;
  logic       cpu_req_i;
  logic       cpu_we_i;
  addr_t      cpu_addr_i;
  word_t      cpu_wdata_i;
  logic       cpu_ack_o;
  word_t      cpu_rdata_o;
  logic       snoop_req_i;
  logic       snoop_inv_i;
  addr_t      snoop_addr_i;
  logic       snoop_ack_o;
  logic       snoop_hit_o;
  logic       snoop_dirty_o;
  line_t      snoop_data_o;
  logic       mem_req_o;
  logic       mem_we_o;
  addr_t      mem_addr_o;
  line_t      mem_wdata_o;
  word_mask_t mem_wmask_o;
  logic       mem_ack_i;
  line_t      mem_rdata_i;

  // reference memory and transaction log
  word_t      mem_words [0:4095];
  int         rd_count;
  int         wr_count;
  addr_t      last_rd_addr;
  addr_t      last_wr_addr;
  line_t      last_wr_data;
  word_mask_t last_wr_mask;

  always #20 clk_i = ~clk_i;

  dcache_top #(
    .NUM_SETS       ( NumSets       ),
    .UNCACHED_LIMIT ( UncachedLimit )
  ) UUT (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .cpu_req_i     ( cpu_req_i     ),
    .cpu_we_i      ( cpu_we_i      ),
    .cpu_addr_i    ( cpu_addr_i    ),
    .cpu_wdata_i   ( cpu_wdata_i   ),
    .cpu_ack_o     ( cpu_ack_o     ),
    .cpu_rdata_o   ( cpu_rdata_o   ),
    .snoop_req_i   ( snoop_req_i   ),
    .snoop_inv_i   ( snoop_inv_i   ),
    .snoop_addr_i  ( snoop_addr_i  ),
    .snoop_ack_o   ( snoop_ack_o   ),
    .snoop_hit_o   ( snoop_hit_o   ),
    .snoop_dirty_o ( snoop_dirty_o ),
    .snoop_data_o  ( snoop_data_o  ),
    .mem_req_o     ( mem_req_o     ),
    .mem_we_o      ( mem_we_o      ),
    .mem_addr_o    ( mem_addr_o    ),
    .mem_wdata_o   ( mem_wdata_o   ),
    .mem_wmask_o   ( mem_wmask_o   ),
    .mem_ack_i     ( mem_ack_i     ),
    .mem_rdata_i   ( mem_rdata_i   )
  );

  function automatic word_t fill_word(input addr_t a);
    return (a * 32'h9E37_79B9) ^ 32'h0F1E_2D3C;
  endfunction

  function automatic word_t word_at(input addr_t a);
    return mem_words[a[13:2]];
  endfunction

  function automatic line_t line_at(input addr_t a);
    line_t l;
    for (int i = 0; i < WordsPerLine; i++) begin
      l[i*32 +: 32] = mem_words[{a[13:4], 2'b00} + i];
    end
    return l;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("error at %0t ns: %s is %0h, expected %0h",
                         $time, name, actual, expected));
    end
  endtask

  // memory acks after 0 to 3 cycles and holds ack until req falls
  initial begin : mem_model
    int         delay;
    addr_t      req_addr;
    logic       req_we;
    line_t      req_wdata;
    word_mask_t req_wmask;
    void'($urandom(62));
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    rd_count    = 0;
    wr_count    = 0;
    for (int i = 0; i < 4096; i++) begin
      mem_words[i] = fill_word(i * 4);
    end
    forever begin
      @(negedge clk_i);
      if (mem_req_o && !mem_ack_i) begin
        req_addr  = mem_addr_o;
        req_we    = mem_we_o;
        req_wdata = mem_wdata_o;
        req_wmask = mem_wmask_o;
        delay     = $urandom % 4;
        repeat (delay) @(posedge clk_i);
        @(posedge clk_i);
        if (req_we) begin
          for (int i = 0; i < WordsPerLine; i++) begin
            if (req_wmask[i]) begin
              mem_words[{req_addr[13:4], 2'b00} + i] = req_wdata[i*32 +: 32];
            end
          end
          wr_count++;
          last_wr_addr = req_addr;
          last_wr_data = req_wdata;
          last_wr_mask = req_wmask;
          mem_rdata_i <= '0;
        end else begin
          rd_count++;
          last_rd_addr = req_addr;
          mem_rdata_i <= line_at(req_addr);
        end
        mem_ack_i <= 1'b1;
        do @(negedge clk_i); while (mem_req_o);
        @(posedge clk_i);
        mem_ack_i   <= 1'b0;
        mem_rdata_i <= '0;
      end
    end
  end

  // latency counts edges from the one that samples req to the one that raises ack
  task automatic cpu_access(input logic we, input addr_t addr, input word_t wdata,
                            output word_t rdata, output int latency);
    int n;
    n = 0;
    @(posedge clk_i);
    cpu_req_i   <= 1'b1;
    cpu_we_i    <= we;
    cpu_addr_i  <= addr;
    cpu_wdata_i <= wdata;
    do begin
      @(negedge clk_i);
      n++;
      if (n > HandshakeLimit) fail_run("processor ack did not rise in time");
    end while (!cpu_ack_o);
    rdata   = cpu_rdata_o;
    latency = n - 2;
    @(posedge clk_i);
    cpu_req_i <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (n > HandshakeLimit) fail_run("processor ack did not fall after req dropped");
    end while (cpu_ack_o);
  endtask

  task automatic snoop_access(input addr_t addr, input logic inv, output logic hit,
                              output logic dirty, output line_t data);
    int n;
    n = 0;
    @(posedge clk_i);
    snoop_req_i  <= 1'b1;
    snoop_inv_i  <= inv;
    snoop_addr_i <= addr;
    do begin
      @(negedge clk_i);
      n++;
      if (n > HandshakeLimit) fail_run("snoop ack did not rise in time");
    end while (!snoop_ack_o);
    hit   = snoop_hit_o;
    dirty = snoop_dirty_o;
    data  = snoop_data_o;
    @(posedge clk_i);
    snoop_req_i <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (n > HandshakeLimit) fail_run("snoop ack did not fall after req dropped");
    end while (snoop_ack_o);
  endtask

  task automatic read_miss_then_hit();
    word_t exp0;
    word_t exp1;
    word_t rd;
    int    lat;
    int    rd0;
    int    wr0;
    exp0 = word_at(32'h0000_1040);
    exp1 = word_at(32'h0000_1044);
    rd0  = rd_count;
    wr0  = wr_count;
    cpu_access(1'b0, 32'h0000_1040, '0, rd, lat);
    check_value("cpu_rdata_o", rd, exp0);
    check_value("memory read count", rd_count - rd0, 1);
    check_value("memory write count", wr_count - wr0, 0);
    check_value("mem_addr_o", last_rd_addr, 32'h0000_1040);
    // same line again stays inside the cache
    rd0 = rd_count;
    cpu_access(1'b0, 32'h0000_1044, '0, rd, lat);
    check_value("cpu_rdata_o", rd, exp1);
    check_value("memory read count", rd_count - rd0, 0);
    check_value("memory write count", wr_count - wr0, 0);
    check_value("cpu_ack_o latency", lat, 2);
  endtask

  task automatic write_then_read();
    word_t rd;
    int    lat;
    int    wr0;
    wr0 = wr_count;
    cpu_access(1'b1, 32'h0000_1050, 32'hDEAD_BEEF, rd, lat);
    cpu_access(1'b0, 32'h0000_1050, '0, rd, lat);
    check_value("cpu_rdata_o", rd, 32'hDEAD_BEEF);
    check_value("cpu_ack_o latency", lat, 2);
    check_value("memory write count", wr_count - wr0, 0);
  endtask

  task automatic dirty_victim_eviction();
    line_t victim;
    word_t exp_rd;
    word_t rd;
    int    lat;
    int    rd0;
    int    wr0;
    victim = line_at(32'h0000_1060);
    victim[2*32 +: 32] = 32'h1234_5678;
    exp_rd = word_at(32'h0000_2060);
    cpu_access(1'b1, 32'h0000_1068, 32'h1234_5678, rd, lat);
    rd0 = rd_count;
    wr0 = wr_count;
    // same index with another tag evicts the dirty line
    cpu_access(1'b0, 32'h0000_2060, '0, rd, lat);
    check_value("memory write count", wr_count - wr0, 1);
    check_value("mem_addr_o", last_wr_addr, 32'h0000_1060);
    check_value("mem_wdata_o", last_wr_data, victim);
    check_value("mem_wmask_o", last_wr_mask, 4'hF);
    check_value("memory read count", rd_count - rd0, 1);
    check_value("mem_addr_o", last_rd_addr, 32'h0000_2060);
    check_value("cpu_rdata_o", rd, exp_rd);
    check_value("memory word 0x1068", word_at(32'h0000_1068), 32'h1234_5678);
  endtask

  task automatic uncached_accesses();
    word_t rd;
    int    lat;
    int    rd0;
    int    wr0;
    rd0 = rd_count;
    wr0 = wr_count;
    cpu_access(1'b1, 32'h0000_0048, 32'hCAFE_F00D, rd, lat);
    check_value("memory write count", wr_count - wr0, 1);
    check_value("mem_addr_o", last_wr_addr, 32'h0000_0040);
    check_value("mem_wmask_o", last_wr_mask, 4'b0100);
    check_value("memory read count", rd_count - rd0, 0);
    for (int i = 1; i <= 2; i++) begin
      cpu_access(1'b0, 32'h0000_0048, '0, rd, lat);
      check_value("cpu_rdata_o", rd, 32'hCAFE_F00D);
      check_value("memory read count", rd_count - rd0, i);
      check_value("mem_addr_o", last_rd_addr, 32'h0000_0040);
    end
    check_value("memory write count", wr_count - wr0, 1);
  endtask

  task automatic dirty_line_snoops();
    line_t exp_line;
    word_t stale;
    word_t rd;
    int    lat;
    int    rd0;
    int    wr0;
    logic  hit;
    logic  dirty;
    line_t data;
    exp_line = line_at(32'h0000_3080);
    exp_line[1*32 +: 32] = 32'h5A5A_1234;
    stale = word_at(32'h0000_3084);
    cpu_access(1'b1, 32'h0000_3084, 32'h5A5A_1234, rd, lat);
    rd0 = rd_count;
    wr0 = wr_count;
    snoop_access(32'h0000_3080, 1'b0, hit, dirty, data);
    check_value("snoop_hit_o", hit, 1'b1);
    check_value("snoop_dirty_o", dirty, 1'b1);
    check_value("snoop_data_o", data, exp_line);
    // ownership of the dirty data moved to the snooper
    snoop_access(32'h0000_3080, 1'b0, hit, dirty, data);
    check_value("snoop_hit_o", hit, 1'b1);
    check_value("snoop_dirty_o", dirty, 1'b0);
    snoop_access(32'h0000_3080, 1'b1, hit, dirty, data);
    check_value("snoop_hit_o", hit, 1'b1);
    check_value("memory read count", rd_count - rd0, 0);
    check_value("memory write count", wr_count - wr0, 0);
    cpu_access(1'b0, 32'h0000_3084, '0, rd, lat);
    check_value("memory read count", rd_count - rd0, 1);
    check_value("mem_addr_o", last_rd_addr, 32'h0000_3080);
    check_value("cpu_rdata_o", rd, stale);
  endtask

  task automatic absent_line_snoops();
    int    rd0;
    int    wr0;
    logic  hit;
    logic  dirty;
    line_t data;
    rd0 = rd_count;
    wr0 = wr_count;
    snoop_access(32'h0000_7000, 1'b0, hit, dirty, data);
    check_value("snoop_hit_o", hit, 1'b0);
    // set 4 holds tag 0x10, so this one differs only in the tag
    snoop_access(32'h0000_5040, 1'b0, hit, dirty, data);
    check_value("snoop_hit_o", hit, 1'b0);
    check_value("snoop_dirty_o", dirty, 1'b0);
    check_value("memory read count", rd_count - rd0, 0);
    check_value("memory write count", wr_count - wr0, 0);
  endtask

  initial begin : watchdog
    repeat (ResetCycles + NumAccesses * 200) @(posedge clk_i);
    fail_run("watchdog expired before the tests finished");
  end

  initial begin : main
    rst_n_i      = 1'b0;
    cpu_req_i    = 1'b0;
    cpu_we_i     = 1'b0;
    cpu_addr_i   = '0;
    cpu_wdata_i  = '0;
    snoop_req_i  = 1'b0;
    snoop_inv_i  = 1'b0;
    snoop_addr_i = '0;
    repeat (ResetCycles) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_value("cpu_ack_o", cpu_ack_o, 1'b0);
    check_value("snoop_ack_o", snoop_ack_o, 1'b0);
    check_value("mem_req_o", mem_req_o, 1'b0);
    read_miss_then_hit();
    write_then_read();
    dirty_victim_eviction();
    uncached_accesses();
    dirty_line_snoops();
    absent_line_snoops();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
// Every port is a four-phase req/ack handshake and addresses below UNCACHED_LIMIT bypass the cache
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; #(
  parameter int unsigned NUM_SETS       = 16,
  parameter addr_t       UNCACHED_LIMIT = 32'h0000_0100
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // processor port
  input  logic       cpu_req_i,
  input  logic       cpu_we_i,
  input  addr_t      cpu_addr_i,
  input  word_t      cpu_wdata_i,
  output logic       cpu_ack_o,
  output word_t      cpu_rdata_o,
  // snoop port
  input  logic       snoop_req_i,
  input  logic       snoop_inv_i,
  input  addr_t      snoop_addr_i,
  output logic       snoop_ack_o,
  output logic       snoop_hit_o,
  output logic       snoop_dirty_o,
  output line_t      snoop_data_o,
  // memory port
  output logic       mem_req_o,
  output logic       mem_we_o,
  output addr_t      mem_addr_o,
  output line_t      mem_wdata_o,
  output word_mask_t mem_wmask_o,
  input  logic       mem_ack_i,
  input  line_t      mem_rdata_i
);

  logic snoop_pend;
  logic snoop_done;
  logic snoop_gnt;

  line_port_if ctrl_line ();
  line_port_if snp_line ();
  mem_port_if  mem_bus ();

  dcache_ctrl #(
    .NUM_SETS       ( NUM_SETS       ),
    .UNCACHED_LIMIT ( UNCACHED_LIMIT )
  ) u_ctrl (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .cpu_req_i    ( cpu_req_i   ),
    .cpu_we_i     ( cpu_we_i    ),
    .cpu_addr_i   ( cpu_addr_i  ),
    .cpu_wdata_i  ( cpu_wdata_i ),
    .cpu_ack_o    ( cpu_ack_o   ),
    .cpu_rdata_o  ( cpu_rdata_o ),
    .snoop_pend_i ( snoop_pend  ),
    .snoop_done_i ( snoop_done  ),
    .snoop_gnt_o  ( snoop_gnt   ),
    .store        ( ctrl_line   ),
    .mem          ( mem_bus     )
  );

  snoop_unit #(
    .NUM_SETS ( NUM_SETS )
  ) u_snoop (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .snoop_req_i   ( snoop_req_i   ),
    .snoop_inv_i   ( snoop_inv_i   ),
    .snoop_addr_i  ( snoop_addr_i  ),
    .snoop_ack_o   ( snoop_ack_o   ),
    .snoop_hit_o   ( snoop_hit_o   ),
    .snoop_dirty_o ( snoop_dirty_o ),
    .snoop_data_o  ( snoop_data_o  ),
    .snoop_pend_o  ( snoop_pend    ),
    .snoop_done_o  ( snoop_done    ),
    .snoop_gnt_i   ( snoop_gnt     ),
    .store         ( snp_line      )
  );

  dcache_line_store #(
    .NUM_SETS ( NUM_SETS )
  ) u_store (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .ctrl_port   ( ctrl_line ),
    .snp_port    ( snp_line  ),
    .snoop_gnt_i ( snoop_gnt )
  );

  mem_arbiter u_arb (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .client      ( mem_bus     ),
    .mem_req_o   ( mem_req_o   ),
    .mem_we_o    ( mem_we_o    ),
    .mem_addr_o  ( mem_addr_o  ),
    .mem_wdata_o ( mem_wdata_o ),
    .mem_wmask_o ( mem_wmask_o ),
    .mem_ack_i   ( mem_ack_i   ),
    .mem_rdata_i ( mem_rdata_i )
  );

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
// Single client adapter where req and ack pass through without delay and rdata is held from rising ack
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import dcache_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  mem_port_if.arbiter        client,
  output logic               mem_req_o,
  output logic               mem_we_o,
  output addr_t              mem_addr_o,
  output line_t              mem_wdata_o,
  output word_mask_t         mem_wmask_o,
  input  logic               mem_ack_i,
  input  line_t              mem_rdata_i
);

  logic  ack_q;
  line_t rdata_q;

  assign mem_req_o   = client.req;
  assign mem_we_o    = client.we;
  assign mem_addr_o  = client.addr;
  assign mem_wdata_o = client.wdata;
  assign mem_wmask_o = client.wmask;
  assign client.ack  = mem_ack_i;

  // edge detect on ack
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= mem_ack_i;
    end
  end

  // memory may drop its data together with ack
  always_ff @(posedge clk_i) begin
    if (mem_ack_i && !ack_q) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign client.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== snoop_unit.sv ====
// Snooper holds snoop_req_i and its fields until ack and the lookup waits for the controller grant
`timescale 1ns/1ps
`default_nettype none

module snoop_unit import dcache_pkg::*; #(
  parameter int unsigned NUM_SETS = 16
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           snoop_req_i,
  input  logic           snoop_inv_i,
  input  addr_t          snoop_addr_i,
  output logic           snoop_ack_o,
  output logic           snoop_hit_o,
  output logic           snoop_dirty_o,
  output line_t          snoop_data_o,
  output logic           snoop_pend_o,
  output logic           snoop_done_o,
  input  logic           snoop_gnt_i,
  line_port_if.requester store
);

  localparam int unsigned IndexBits = $clog2(NUM_SETS);
  localparam int unsigned TagBits   = 32 - OffsetBits - IndexBits;

  snoop_state_t state_q;
  logic         ack_q;

  addr_t addr_q;
  logic  inv_q;
  logic  hit_q;
  logic  dirty_q;
  line_t data_q;
  tag_t  snp_tag;

  assign snp_tag = tag_t'(addr_q[31 -: TagBits]);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= SNP_IDLE;
      ack_q   <= 1'b0;
    end else begin
      case (state_q)
        SNP_IDLE:     if (snoop_req_i) state_q <= SNP_WAIT_GNT;
        SNP_WAIT_GNT: if (snoop_gnt_i) state_q <= SNP_LOOKUP;
        SNP_LOOKUP:   state_q <= SNP_UPDATE;
        SNP_UPDATE: begin
          ack_q   <= 1'b1;
          state_q <= SNP_RESPOND;
        end
        SNP_RESPOND: begin
          if (!snoop_req_i) begin
            ack_q   <= 1'b0;
            state_q <= SNP_IDLE;
          end
        end
        default: state_q <= SNP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == SNP_IDLE && snoop_req_i) begin
      addr_q <= snoop_addr_i;
      inv_q  <= snoop_inv_i;
    end
    if (state_q == SNP_LOOKUP) begin
      hit_q   <= store.rvalid && (store.rtag == snp_tag);
      // previous dirty state goes back to the snooper
      dirty_q <= store.rvalid && (store.rtag == snp_tag) && store.rdirty;
      data_q  <= store.rdata;
    end
  end

  // read when granted, then write the hit entry back clean and optionally invalid
  assign store.en     = (state_q == SNP_WAIT_GNT && snoop_gnt_i) || (state_q == SNP_UPDATE && hit_q);
  assign store.we     = (state_q == SNP_UPDATE);
  assign store.index  = index_t'(addr_q[OffsetBits +: IndexBits]);
  assign store.wtag   = snp_tag;
  assign store.wvalid = !inv_q;
  assign store.wdirty = 1'b0;
  assign store.wdata  = data_q;

  assign snoop_pend_o  = (state_q == SNP_WAIT_GNT);
  assign snoop_done_o  = (state_q == SNP_UPDATE);
  assign snoop_ack_o   = ack_q;
  assign snoop_hit_o   = hit_q;
  assign snoop_dirty_o = dirty_q;
  assign snoop_data_o  = data_q;

endmodule

`default_nettype wire

// ==== dcache_ctrl.sv ====
// Requester must keep req and its fields stable until ack and may raise req again only after ack falls
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; #(
  parameter int unsigned NUM_SETS       = 16,
  parameter addr_t       UNCACHED_LIMIT = 32'h0000_0100
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           cpu_req_i,
  input  logic           cpu_we_i,
  input  addr_t          cpu_addr_i,
  input  word_t          cpu_wdata_i,
  output logic           cpu_ack_o,
  output word_t          cpu_rdata_o,
  input  logic           snoop_pend_i,
  input  logic           snoop_done_i,
  output logic           snoop_gnt_o,
  line_port_if.requester store,
  mem_port_if.client     mem
);

  localparam int unsigned IndexBits = $clog2(NUM_SETS);
  localparam int unsigned TagBits   = 32 - OffsetBits - IndexBits;

  ctrl_state_t state_q;
  logic        ack_q;
  logic        mem_req_q;
  logic        gnt_q;

  addr_t addr_q;
  logic  we_q;
  word_t wdata_q;
  line_t line_q;
  tag_t  victim_tag_q;
  word_t rdata_q;

  logic [1:0] word_sel;
  tag_t       req_tag;
  logic       hit;
  logic       mem_idle;
  logic       take_req;
  line_t      refill_line;

  function automatic line_t merge_word(line_t line, logic [1:0] sel, word_t w);
    line_t res;
    res = line;
    res[sel*32 +: 32] = w;
    return res;
  endfunction

  assign word_sel    = addr_q[3:2];
  assign req_tag     = tag_t'(addr_q[31 -: TagBits]);
  assign hit         = store.rvalid && (store.rtag == req_tag);
  // memory handshake fully returned to zero
  assign mem_idle    = !mem_req_q && !mem.ack;
  // a waiting snoop goes first
  assign take_req    = cpu_req_i && !snoop_pend_i;
  assign refill_line = we_q ? merge_word(mem.rdata, word_sel, wdata_q) : mem.rdata;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= CTRL_IDLE;
      ack_q     <= 1'b0;
      mem_req_q <= 1'b0;
      gnt_q     <= 1'b0;
    end else begin
      case (state_q)
        CTRL_IDLE: begin
          if (snoop_pend_i) begin
            gnt_q   <= 1'b1;
            state_q <= CTRL_SNOOP_GRANT;
          end else if (cpu_req_i) begin
            if (cpu_addr_i < UNCACHED_LIMIT) begin
              mem_req_q <= 1'b1;
              state_q   <= CTRL_BYPASS;
            end else begin
              state_q <= CTRL_LOOKUP;
            end
          end
        end
        CTRL_LOOKUP: begin
          if (hit) begin
            state_q <= CTRL_RESPOND;
          end else begin
            mem_req_q <= 1'b1;
            state_q   <= (store.rvalid && store.rdirty) ? CTRL_WRITEBACK : CTRL_REFILL;
          end
        end
        CTRL_WRITEBACK: begin
          if (mem_req_q && mem.ack) begin
            mem_req_q <= 1'b0;
          end else if (mem_idle) begin
            mem_req_q <= 1'b1;
            state_q   <= CTRL_REFILL;
          end
        end
        CTRL_REFILL, CTRL_BYPASS: begin
          if (mem_req_q && mem.ack) begin
            mem_req_q <= 1'b0;
          end else if (mem_idle) begin
            state_q <= CTRL_RESPOND;
          end
        end
        CTRL_RESPOND: begin
          // one cycle here gives the two-cycle hit latency
          if (!ack_q) begin
            ack_q <= 1'b1;
          end else if (!cpu_req_i) begin
            ack_q   <= 1'b0;
            state_q <= CTRL_IDLE;
          end
        end
        CTRL_SNOOP_GRANT: begin
          if (snoop_done_i) begin
            gnt_q   <= 1'b0;
            state_q <= CTRL_IDLE;
          end
        end
        default: state_q <= CTRL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == CTRL_IDLE && take_req) begin
      addr_q  <= cpu_addr_i;
      we_q    <= cpu_we_i;
      wdata_q <= cpu_wdata_i;
    end
    if (state_q == CTRL_LOOKUP) begin
      line_q       <= store.rdata;
      victim_tag_q <= store.rtag;
      rdata_q      <= store.rdata[word_sel*32 +: 32];
    end
    if ((state_q == CTRL_REFILL || state_q == CTRL_BYPASS) && mem_idle) begin
      rdata_q <= mem.rdata[word_sel*32 +: 32];
    end
  end

  always_comb begin
    store.en     = 1'b0;
    store.we     = 1'b0;
    store.index  = index_t'(addr_q[OffsetBits +: IndexBits]);
    store.wtag   = req_tag;
    store.wvalid = 1'b1;
    store.wdirty = we_q;
    store.wdata  = refill_line;
    case (state_q)
      CTRL_IDLE: begin
        store.en    = take_req && (cpu_addr_i >= UNCACHED_LIMIT);
        store.index = index_t'(cpu_addr_i[OffsetBits +: IndexBits]);
      end
      CTRL_LOOKUP: begin
        // write hit updates the line in place and marks it dirty
        store.en    = hit && we_q;
        store.we    = 1'b1;
        store.wdata = merge_word(store.rdata, word_sel, wdata_q);
      end
      CTRL_REFILL: begin
        store.en = mem_idle;
        store.we = 1'b1;
      end
      default: ;
    endcase
  end

  assign mem.req   = mem_req_q;
  assign mem.we    = (state_q == CTRL_WRITEBACK) || (state_q == CTRL_BYPASS && we_q);
  assign mem.addr  = (state_q == CTRL_WRITEBACK) ?
                     {victim_tag_q[TagBits-1:0], addr_q[OffsetBits +: IndexBits],
                      OffsetBits'(0)} :
                     {addr_q[31:OffsetBits], OffsetBits'(0)};
  assign mem.wdata = (state_q == CTRL_WRITEBACK) ? line_q : {WordsPerLine{wdata_q}};
  // uncached write touches only the addressed word
  assign mem.wmask = (state_q == CTRL_WRITEBACK) ? '1 :
                     (state_q == CTRL_BYPASS && we_q) ? word_mask_t'(1) << word_sel : '0;

  assign cpu_ack_o   = ack_q;
  assign cpu_rdata_o = rdata_q;
  assign snoop_gnt_o = gnt_q;

endmodule

`default_nettype wire

// ==== dcache_line_store.sv ====
// Single-ported arrays with synchronous read where the snoop unit wins only while snoop_gnt_i is high
`timescale 1ns/1ps
`default_nettype none

module dcache_line_store import dcache_pkg::*; #(
  parameter int unsigned NUM_SETS = 16
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  line_port_if.store ctrl_port,
  line_port_if.store snp_port,
  input  logic       snoop_gnt_i
);

  localparam int unsigned IndexBits = $clog2(NUM_SETS);
  localparam int unsigned TagBits   = 32 - OffsetBits - IndexBits;

  logic [TagBits-1:0]  tag_mem [NUM_SETS];
  line_t               data_mem [NUM_SETS];
  logic [NUM_SETS-1:0] valid_q;
  logic [NUM_SETS-1:0] dirty_q;

  logic                 sel_en;
  logic                 sel_we;
  logic [IndexBits-1:0] sel_idx;
  tag_t                 sel_wtag;
  logic                 sel_wvalid;
  logic                 sel_wdirty;
  line_t                sel_wdata;

  logic [TagBits-1:0] rtag_q;
  logic               rvalid_q;
  logic               rdirty_q;
  line_t              rdata_q;

  // port select
  always_comb begin
    if (snoop_gnt_i) begin
      sel_en     = snp_port.en;
      sel_we     = snp_port.we;
      sel_idx    = snp_port.index[IndexBits-1:0];
      sel_wtag   = snp_port.wtag;
      sel_wvalid = snp_port.wvalid;
      sel_wdirty = snp_port.wdirty;
      sel_wdata  = snp_port.wdata;
    end else begin
      sel_en     = ctrl_port.en;
      sel_we     = ctrl_port.we;
      sel_idx    = ctrl_port.index[IndexBits-1:0];
      sel_wtag   = ctrl_port.wtag;
      sel_wvalid = ctrl_port.wvalid;
      sel_wdirty = ctrl_port.wdirty;
      sel_wdata  = ctrl_port.wdata;
    end
  end

  // all sets start out invalid
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (sel_en && sel_we) begin
      valid_q[sel_idx] <= sel_wvalid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_en && sel_we) begin
      tag_mem[sel_idx]  <= sel_wtag[TagBits-1:0];
      data_mem[sel_idx] <= sel_wdata;
      dirty_q[sel_idx]  <= sel_wdirty;
    end
    if (sel_en && !sel_we) begin
      rtag_q   <= tag_mem[sel_idx];
      rvalid_q <= valid_q[sel_idx];
      rdirty_q <= dirty_q[sel_idx];
      rdata_q  <= data_mem[sel_idx];
    end
  end

  // both requesters see the same read register
  assign ctrl_port.rtag   = tag_t'(rtag_q);
  assign ctrl_port.rvalid = rvalid_q;
  assign ctrl_port.rdirty = rdirty_q;
  assign ctrl_port.rdata  = rdata_q;
  assign snp_port.rtag    = tag_t'(rtag_q);
  assign snp_port.rvalid  = rvalid_q;
  assign snp_port.rdirty  = rdirty_q;
  assign snp_port.rdata   = rdata_q;

endmodule

`default_nettype wire

// ==== mem_port_if.sv ====
// Four-phase link where the client holds every request field stable from req up to ack
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if import dcache_pkg::*; ();

  logic       req;
  logic       we;
  addr_t      addr;
  line_t      wdata;
  word_mask_t wmask;
  logic       ack;
  // stays valid through the falling half of the handshake
  line_t      rdata;

  modport client (
    output req, we, addr, wdata, wmask,
    input  ack, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata, wmask,
    output ack, rdata
  );

endinterface

`default_nettype wire

// ==== line_port_if.sv ====
// Read data is valid one cycle after en with we low and a write replaces the whole entry
`timescale 1ns/1ps
`default_nettype none

interface line_port_if import dcache_pkg::*; ();

  // requester side
  logic   en;
  logic   we;
  index_t index;
  tag_t   wtag;
  logic   wvalid;
  logic   wdirty;
  line_t  wdata;

  // store side, held until the next read
  tag_t   rtag;
  logic   rvalid;
  logic   rdirty;
  line_t  rdata;

  modport requester (
    output en, we, index, wtag, wvalid, wdirty, wdata,
    input  rtag, rvalid, rdirty, rdata
  );

  modport store (
    input  en, we, index, wtag, wvalid, wdirty, wdata,
    output rtag, rvalid, rdirty, rdata
  );

endinterface

`default_nettype wire

// ==== dcache_pkg.sv ====
// Line geometry is fixed at four 32-bit words and NUM_SETS must be a power of two from 2 to 256
`default_nettype none

package dcache_pkg;

  // byte address and data word seen on the processor and snoop ports
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  localparam int unsigned WordsPerLine = 4;
  // byte offset inside a line; address bits 3:2 pick the word
  localparam int unsigned OffsetBits = 4;
  // bounds the index width to 256 sets
  localparam int unsigned MaxSetBits = 8;

  // word 0 sits in the low 32 bits
  typedef logic [WordsPerLine*32-1:0] line_t;
  // one bit per word of a line for memory writes
  typedef logic [WordsPerLine-1:0] word_mask_t;

  // sized for the widest case, each module keeps only the low bits it derives from NUM_SETS
  typedef logic [MaxSetBits-1:0] index_t;
  typedef logic [31-OffsetBits:0] tag_t;

  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_LOOKUP,
    CTRL_WRITEBACK,
    CTRL_REFILL,
    CTRL_BYPASS,
    CTRL_RESPOND,
    CTRL_SNOOP_GRANT
  } ctrl_state_t;

  typedef enum logic [2:0] {
    SNP_IDLE,
    SNP_WAIT_GNT,
    SNP_LOOKUP,
    SNP_UPDATE,
    SNP_RESPOND
  } snoop_state_t;

endpackage

`default_nettype wire
